//--- project.f
verilog/fifo_pkg.sv
verilog/store_if.sv
verilog/word_writer.sv
verilog/word_store.sv
verilog/lane_reader.sv
verilog/fifo_status.sv
verilog/width_fifo.sv
test/width_fifo_properties.sv
test/width_fifo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= width_fifo_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL

SRCS := $(wildcard verilog/*.sv test/*.sv)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	    --Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "sim: failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/width_fifo_tb.sv
`timescale 1ns/1ps

module width_fifo_tb;

    import fifo_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int RAND_OPS    = 400;
    localparam int OP_BUDGET   = 4;
    localparam int TOTAL_OPS   = RAND_OPS + 3 * DEPTH * LANES;
    localparam int DRAIN_LIMIT = DEPTH * LANES + 8;

    typedef struct packed {
        logic                  full;
        logic                  empty;
        logic                  almost_full;
        logic                  almost_empty;
        logic                  prog_full;
        logic                  prog_empty;
        logic [WPTR_WIDTH-1:0] wr_count;
        logic [WPTR_WIDTH-1:0] wr_space;
        logic [RPTR_WIDTH-1:0] rd_count;
        logic [RPTR_WIDTH-1:0] rd_space;
    } status_t;

    logic                  clock;
    logic                  sys_rst;
    logic                  wr_en;
    logic                  rd_en;
    logic [WORD_WIDTH-1:0] din;
    logic [LANE_WIDTH-1:0] dout;
    logic                  wr_ready;
    logic                  valid;
    logic                  full;
    logic                  empty;
    logic                  overflow;
    logic                  underflow;
    logic                  wr_ack;
    logic                  almost_full;
    logic                  almost_empty;
    logic                  prog_full;
    logic                  prog_empty;
    logic [WPTR_WIDTH-1:0] wr_data_count;
    logic [WPTR_WIDTH-1:0] wr_data_space;
    logic [RPTR_WIDTH-1:0] rd_data_count;
    logic [RPTR_WIDTH-1:0] rd_data_space;

    // model of the lanes still to be read, head first
    logic [LANE_WIDTH-1:0] lane_q[$];
    logic                  exp_valid;
    logic                  exp_overflow;
    logic                  exp_underflow;
    int                    data_errors;
    int                    status_errors;
    int                    handshake_errors;
    logic [31:0]           lfsr_state;

    width_fifo dut0 (.*);

    bind width_fifo width_fifo_properties props0 (
        .clock (clock), .sys_rst (sys_rst), .rd_en (rd_en), .wr_ack (wr_ack),
        .full (full), .empty (empty), .valid (valid), .dout (dout)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    // counts and flags for a given number of unread lanes
    function automatic status_t ref_status(input int lanes);
        status_t s;
        int      words;
        words          = (lanes + LANES - 1) / LANES;
        s.wr_count     = WPTR_WIDTH'(words);
        s.wr_space     = WPTR_WIDTH'(DEPTH - words);
        s.rd_count     = RPTR_WIDTH'(lanes);
        s.rd_space     = RPTR_WIDTH'(DEPTH * LANES - lanes);
        s.full         = (words == DEPTH);
        s.empty        = (words == 0);
        s.almost_full  = (words == DEPTH - 1);
        s.almost_empty = (lanes == 1);
        s.prog_full    = (lanes >= PROG_FULL_THRESH);
        s.prog_empty   = (lanes <= PROG_EMPTY_THRESH);
        return s;
    endfunction

    task automatic record_mismatch(input int kind, input string what,
                                   input logic [31:0] got, input logic [31:0] want);
        $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, got, want);
        case (kind)
            0: data_errors++;
            1: status_errors++;
            default: handshake_errors++;
        endcase
    endtask

    task automatic drive_cycle(input logic wr, input logic [WORD_WIDTH-1:0] data, input logic rd);
        wr_en = wr;
        din   = data;
        rd_en = rd;
        @(posedge clock);
        #1;
    endtask

    task automatic drain_all();
        int n;
        n = 0;
        while ((valid || !empty) && n < DRAIN_LIMIT) begin
            drive_cycle(1'b0, '0, 1'b1);
            n++;
        end
        if (n == DRAIN_LIMIT) begin
            $display("drain did not empty the FIFO within %0d cycles", DRAIN_LIMIT);
            handshake_errors++;
        end
    endtask

    // outputs are settled at the falling edge, then the model takes the coming edge
    always @(negedge clock) begin : compare_and_advance
        status_t want;
        int      words;
        logic    consume;
        logic    last_lane;
        if (sys_rst) begin
            want = ref_status(lane_q.size());
            if (full !== want.full) record_mismatch(1, "full", 32'(full), 32'(want.full));
            if (empty !== want.empty) record_mismatch(1, "empty", 32'(empty), 32'(want.empty));
            if (almost_full !== want.almost_full)
                record_mismatch(1, "almost_full", 32'(almost_full), 32'(want.almost_full));
            if (almost_empty !== want.almost_empty)
                record_mismatch(1, "almost_empty", 32'(almost_empty), 32'(want.almost_empty));
            if (prog_full !== want.prog_full)
                record_mismatch(1, "prog_full", 32'(prog_full), 32'(want.prog_full));
            if (prog_empty !== want.prog_empty)
                record_mismatch(1, "prog_empty", 32'(prog_empty), 32'(want.prog_empty));
            if (wr_data_count !== want.wr_count)
                record_mismatch(1, "wr_data_count", 32'(wr_data_count), 32'(want.wr_count));
            if (wr_data_space !== want.wr_space)
                record_mismatch(1, "wr_data_space", 32'(wr_data_space), 32'(want.wr_space));
            if (rd_data_count !== want.rd_count)
                record_mismatch(1, "rd_data_count", 32'(rd_data_count), 32'(want.rd_count));
            if (rd_data_space !== want.rd_space)
                record_mismatch(1, "rd_data_space", 32'(rd_data_space), 32'(want.rd_space));
            if (valid !== exp_valid) record_mismatch(0, "valid", 32'(valid), 32'(exp_valid));
            if (exp_valid && dout !== lane_q[0])
                record_mismatch(0, "dout", 32'(dout), 32'(lane_q[0]));
            if (wr_ack !== (wr_en && !want.full))
                record_mismatch(2, "wr_ack", 32'(wr_ack), 32'(wr_en && !want.full));
            if (wr_ready !== !want.full)
                record_mismatch(2, "wr_ready", 32'(wr_ready), 32'(!want.full));
            if (overflow !== exp_overflow)
                record_mismatch(2, "overflow", 32'(overflow), 32'(exp_overflow));
            if (underflow !== exp_underflow)
                record_mismatch(2, "underflow", 32'(underflow), 32'(exp_underflow));

            words         = (lane_q.size() + LANES - 1) / LANES;
            consume       = rd_en && exp_valid;
            last_lane     = (lane_q.size() % LANES) == 1;
            exp_overflow  = wr_en && want.full;
            exp_underflow = rd_en && !exp_valid;
            // prefetch from idle, or move on to the next word after its last lane
            if (!exp_valid) begin
                exp_valid = (words >= 1);
            end else if (consume && last_lane) begin
                exp_valid = (words >= 2);
            end
            if (consume) void'(lane_q.pop_front());
            if (wr_en && !want.full) begin
                for (int i = 0; i < LANES; i++) begin
                    lane_q.push_back(din[i * LANE_WIDTH +: LANE_WIDTH]);
                end
            end
        end
    end

    initial begin
        #(TOTAL_OPS * OP_BUDGET * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", TOTAL_OPS * OP_BUDGET);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int                    latency;
        logic                  wr_bit;
        logic                  rd_bit;
        logic [WORD_WIDTH-1:0] word;
        data_errors      = 0;
        status_errors    = 0;
        handshake_errors = 0;
        exp_valid        = 1'b0;
        exp_overflow     = 1'b0;
        exp_underflow    = 1'b0;
        lfsr_state       = 32'd75839;
        sys_rst          = 1'b0;
        wr_en            = 1'b0;
        rd_en            = 1'b0;
        din              = '0;
        repeat (2) @(posedge clock);
        #1;
        sys_rst = 1'b1;
        drive_cycle(1'b0, '0, 1'b0);

        // single word, valid one edge after acceptance
        drive_cycle(1'b1, 32'ha3b2_c1d0, 1'b0);
        latency = 0;
        while (!valid && latency < 8) begin
            drive_cycle(1'b0, '0, 1'b0);
            latency++;
        end
        if (latency != 1) record_mismatch(2, "write to valid latency", 32'(latency), 32'd1);
        repeat (LANES) drive_cycle(1'b0, '0, 1'b1);
        drive_cycle(1'b0, '0, 1'b0);

        // read with nothing held
        drive_cycle(1'b0, '0, 1'b1);
        drive_cycle(1'b0, '0, 1'b0);

        for (int n = 0; n < RAND_OPS; n++) begin
            wr_bit = (random_bits(2) == 32'd0);
            word   = random_bits(WORD_WIDTH);
            rd_bit = (random_bits(2) != 32'd0);
            drive_cycle(wr_bit, word, rd_bit);
        end
        drain_all();

        // fill to full, one rejected write, then drain
        repeat (DEPTH) drive_cycle(1'b1, random_bits(WORD_WIDTH), 1'b0);
        if (!full || wr_ready) record_mismatch(1, "full after fill", 32'(full), 32'd1);
        drive_cycle(1'b1, random_bits(WORD_WIDTH), 1'b0);
        drive_cycle(1'b0, '0, 1'b0);
        drain_all();
        repeat (2) drive_cycle(1'b0, '0, 1'b0);

        $display("errors: data %0d, status %0d, handshake %0d",
                 data_errors, status_errors, handshake_errors);
        if (data_errors + status_errors + handshake_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- test/width_fifo_properties.sv
`timescale 1ns/1ps

module width_fifo_properties (
    input logic                            clock,
    input logic                            sys_rst,
    input logic                            rd_en,
    input logic                            wr_ack,
    input logic                            full,
    input logic                            empty,
    input logic                            valid,
    input logic [fifo_pkg::LANE_WIDTH-1:0] dout
);

    // an acknowledged word is counted by the next cycle
    ack_lands: assert property (
        @(posedge clock) disable iff (!sys_rst) wr_ack |=> !empty
    ) else $error("wr_ack not followed by a stored word");

    // a full FIFO always presents its head lane
    full_shows_head: assert property (
        @(posedge clock) disable iff (!sys_rst) full |-> valid
    ) else $error("full while no head lane is valid");

    // valid only drops after a lane is taken
    valid_held: assert property (
        @(posedge clock) disable iff (!sys_rst) (valid && !rd_en) |=> valid
    ) else $error("valid fell without a consumed lane");

    dout_held: assert property (
        @(posedge clock) disable iff (!sys_rst) (valid && !rd_en) |=> $stable(dout)
    ) else $error("dout changed while waiting for rd_en");

endmodule

//--- verilog/width_fifo.sv
`timescale 1ns/1ps

module width_fifo (
    input  logic                            clock,
    input  logic                            sys_rst,
    input  logic                            wr_en,
    output logic                            wr_ready,
    input  logic [fifo_pkg::WORD_WIDTH-1:0] din,
    input  logic                            rd_en,
    output logic                            valid,
    output logic [fifo_pkg::LANE_WIDTH-1:0] dout,
    output logic                            full,
    output logic                            empty,
    output logic [fifo_pkg::WPTR_WIDTH-1:0] wr_data_count,
    output logic [fifo_pkg::WPTR_WIDTH-1:0] wr_data_space,
    output logic [fifo_pkg::RPTR_WIDTH-1:0] rd_data_count,
    output logic [fifo_pkg::RPTR_WIDTH-1:0] rd_data_space,
    output logic                            almost_full,
    output logic                            almost_empty,
    output logic                            prog_full,
    output logic                            prog_empty,
    output logic                            overflow,
    output logic                            underflow,
    output logic                            wr_ack
);

    import fifo_pkg::*;

    logic [WPTR_WIDTH-1:0] wr_ptr;
    logic [RPTR_WIDTH-1:0] rd_ptr;
    logic [WPTR_WIDTH-1:0] word_count;

    store_if mem_bus ();

    assign wr_ready = ~full;

    word_writer u_writer (
        .clock    (clock),
        .sys_rst  (sys_rst),
        .wr_en    (wr_en),
        .din      (din),
        .full     (full),
        .wr_ack   (wr_ack),
        .overflow (overflow),
        .wr_ptr   (wr_ptr),
        .mem      (mem_bus.writer)
    );

    word_store u_store (
        .clock (clock),
        .mem   (mem_bus.store)
    );

    lane_reader u_reader (
        .clock      (clock),
        .sys_rst    (sys_rst),
        .rd_en      (rd_en),
        .word_count (word_count),
        .valid      (valid),
        .underflow  (underflow),
        .dout       (dout),
        .rd_ptr     (rd_ptr),
        .mem        (mem_bus.reader)
    );

    // flags and counts straight from the two pointers
    fifo_status u_status (
        .wr_ptr        (wr_ptr),
        .rd_ptr        (rd_ptr),
        .word_count    (word_count),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space),
        .almost_full   (almost_full),
        .almost_empty  (almost_empty),
        .prog_full     (prog_full),
        .prog_empty    (prog_empty)
    );

endmodule

//--- verilog/fifo_status.sv
`timescale 1ns/1ps

module fifo_status (
    input  logic [fifo_pkg::WPTR_WIDTH-1:0] wr_ptr,
    input  logic [fifo_pkg::RPTR_WIDTH-1:0] rd_ptr,
    output logic [fifo_pkg::WPTR_WIDTH-1:0] word_count,
    output logic                            full,
    output logic                            empty,
    output logic [fifo_pkg::WPTR_WIDTH-1:0] wr_data_count,
    output logic [fifo_pkg::WPTR_WIDTH-1:0] wr_data_space,
    output logic [fifo_pkg::RPTR_WIDTH-1:0] rd_data_count,
    output logic [fifo_pkg::RPTR_WIDTH-1:0] rd_data_space,
    output logic                            almost_full,
    output logic                            almost_empty,
    output logic                            prog_full,
    output logic                            prog_empty
);

    import fifo_pkg::*;

    logic [WPTR_WIDTH-1:0] rd_word_ptr;
    logic [RPTR_WIDTH-1:0] lanes_taken;

    // a word is released only once its last lane has gone
    assign rd_word_ptr = rd_ptr[RPTR_WIDTH-1:LANE_SEL_WIDTH];
    assign lanes_taken = RPTR_WIDTH'(rd_ptr[LANE_SEL_WIDTH-1:0]);

    // wrap bit makes the difference come out right across the wrap
    assign word_count    = wr_ptr - rd_word_ptr;
    assign wr_data_count = word_count;
    assign wr_data_space = WPTR_WIDTH'(DEPTH) - word_count;

    // lanes still to read, less those already taken from the head word
    assign rd_data_count = RPTR_WIDTH'(word_count * LANES) - lanes_taken;
    assign rd_data_space = RPTR_WIDTH'(LANE_CAPACITY) - rd_data_count;

    assign full        = (word_count == WPTR_WIDTH'(DEPTH));
    assign empty       = (word_count == '0);
    assign almost_full = (word_count == WPTR_WIDTH'(DEPTH - 1));

    // lane based flags
    assign almost_empty = (rd_data_count == RPTR_WIDTH'(1));
    assign prog_full    = (rd_data_count >= RPTR_WIDTH'(PROG_FULL_THRESH));
    assign prog_empty   = (rd_data_count <= RPTR_WIDTH'(PROG_EMPTY_THRESH));

endmodule

//--- verilog/lane_reader.sv
`timescale 1ns/1ps

module lane_reader (
    input  logic                            clock,
    input  logic                            sys_rst,
    input  logic                            rd_en,
    input  logic [fifo_pkg::WPTR_WIDTH-1:0] word_count,
    output logic                            valid,
    output logic                            underflow,
    output logic [fifo_pkg::LANE_WIDTH-1:0] dout,
    output logic [fifo_pkg::RPTR_WIDTH-1:0] rd_ptr,
    store_if.reader                         mem
);

    import fifo_pkg::*;

    reader_state_t                 state;
    reader_state_t                 state_next;
    logic [LANE_SEL_WIDTH-1:0]     lane_sel;
    logic [ADDR_WIDTH-1:0]         head_addr;
    logic                          consume;
    logic                          last_lane;

    // lane select and head word address both come out of the lane pointer
    assign lane_sel  = rd_ptr[LANE_SEL_WIDTH-1:0];
    assign head_addr = rd_ptr[LANE_SEL_WIDTH +: ADDR_WIDTH];

    assign valid     = (state == HOLD);
    assign consume   = rd_en & valid;
    assign last_lane = (lane_sel == LANE_SEL_WIDTH'(LANES - 1));

    // lane 0 is the least significant lane of the held word
    assign dout = mem.rd_data[lane_sel * LANE_WIDTH +: LANE_WIDTH];

    always_comb begin
        state_next  = state;
        mem.rd_en   = 1'b0;
        mem.rd_addr = head_addr;
        case (state)
            IDLE: begin
                // prefetch the head word as soon as one is stored
                if (word_count != '0) begin
                    mem.rd_en  = 1'b1;
                    state_next = HOLD;
                end
            end
            HOLD: begin
                if (consume && last_lane) begin
                    // the held word still counts, so a second one must exist
                    if (word_count > WPTR_WIDTH'(1)) begin
                        mem.rd_en   = 1'b1;
                        mem.rd_addr = head_addr + ADDR_WIDTH'(1);
                    end else begin
                        state_next = IDLE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            state     <= IDLE;
            rd_ptr    <= '0;
            underflow <= 1'b0;
        end else begin
            state     <= state_next;
            underflow <= rd_en & ~valid;
            if (consume) begin
                rd_ptr <= rd_ptr + RPTR_WIDTH'(1);
            end
        end
    end

endmodule

//--- verilog/word_store.sv
`timescale 1ns/1ps

module word_store (
    input  logic   clock,
    store_if.store mem
);

    import fifo_pkg::*;

    logic [WORD_WIDTH-1:0] ram [DEPTH];

    // write port
    always_ff @(posedge clock) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // read port
    // output keeps the last word fetched, which makes it the FWFT hold register
    always_ff @(posedge clock) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];
        end
    end

endmodule

//--- verilog/word_writer.sv
`timescale 1ns/1ps

module word_writer (
    input  logic                            clock,
    input  logic                            sys_rst,
    input  logic                            wr_en,
    input  logic [fifo_pkg::WORD_WIDTH-1:0] din,
    input  logic                            full,
    output logic                            wr_ack,
    output logic                            overflow,
    output logic [fifo_pkg::WPTR_WIDTH-1:0] wr_ptr,
    store_if.writer                         mem
);

    import fifo_pkg::*;

    // a strobe is taken only while there is room
    assign wr_ack = wr_en & ~full;

    // memory write port follows the low pointer bits
    assign mem.wr_en   = wr_ack;
    assign mem.wr_addr = wr_ptr[ADDR_WIDTH-1:0];
    assign mem.wr_data = din;

    // word pointer, wrap bit on top
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr <= '0;
        end else if (wr_ack) begin
            wr_ptr <= wr_ptr + WPTR_WIDTH'(1);
        end
    end

    // rejected strobe shows up one cycle later
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en & full;
        end
    end

endmodule

//--- verilog/store_if.sv
`timescale 1ns/1ps

interface store_if;

    import fifo_pkg::*;

    // write port
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [WORD_WIDTH-1:0] wr_data;

    // read port, rd_data is registered inside the store
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [WORD_WIDTH-1:0] rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport store (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data
    );

endinterface

//--- verilog/fifo_pkg.sv
package fifo_pkg;

    // write side word and read side lane
    localparam int WORD_WIDTH = 32;
    localparam int LANE_WIDTH = 8;

    // lanes per word, lane 0 sits in the least significant bits
    localparam int LANES          = WORD_WIDTH / LANE_WIDTH;
    localparam int LANE_SEL_WIDTH = $clog2(LANES);

    // storage depth in words
    localparam int DEPTH      = 16;
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    // word pointer carries one extra wrap bit
    localparam int WPTR_WIDTH = ADDR_WIDTH + 1;

    // read pointer counts lanes, so the lane select sits below the word pointer
    localparam int RPTR_WIDTH = WPTR_WIDTH + LANE_SEL_WIDTH;

    // total lanes the FIFO can hold
    localparam int LANE_CAPACITY = DEPTH * LANES;

    // programmable flag thresholds, in read side lanes
    localparam int PROG_FULL_THRESH  = 48;
    localparam int PROG_EMPTY_THRESH = 8;

    // reader FSM
    // IDLE means no word is held, HOLD means the memory output holds the head word
    typedef enum logic {
        IDLE = 1'b0,
        HOLD = 1'b1
    } reader_state_t;

endpackage
